// File: vec_params.svh
//////////////////////////////////////////////////////////////////////
// Sizing defines for the vector coprocessor front end
// Vector length, register count and instruction id width
//////////////////////////////////////////////////////////////////////

`ifndef VEC_PARAMS_SVH
`define VEC_PARAMS_SVH

// Bits per vector register
`define VEC_VLEN 128

// Architectural vector registers
`define VEC_NREGS 8

// Instruction id carried from issue to result
`define VEC_ID_W 4

`endif

// File: vec_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared constants and types of the vector coprocessor
// vtype, decoded instruction, unit command and result
//////////////////////////////////////////////////////////////////////

`include "vec_params.svh"

package vec_pkg;

  // Derived sizes
  localparam int unsigned VLEN       = `VEC_VLEN;
  localparam int unsigned VLENB      = VLEN / 8;
  localparam int unsigned ELEN       = 32;
  localparam int unsigned NELEM      = VLEN / ELEN;
  localparam int unsigned VLMAX      = NELEM;
  localparam int unsigned NREGS      = `VEC_NREGS;
  localparam int unsigned ID_W       = `VEC_ID_W;
  localparam int unsigned ELEM_IDX_W = $clog2(NELEM);
  localparam int unsigned REG_IDX_W  = $clog2(NREGS);

  // vtype field encodings
  localparam logic [2:0] SEW_32  = 3'b010;
  localparam logic [2:0] LMUL_1  = 3'b000;
  localparam logic [2:0] LMUL_F2 = 3'b111;
  localparam logic [2:0] LMUL_F4 = 3'b110;

  typedef logic [ID_W-1:0]          id_t;
  typedef logic [ELEN-1:0]          elem_t;
  typedef logic [REG_IDX_W-1:0]     vreg_t;
  // Holds 0 up to VLMAX
  typedef logic [$clog2(VLMAX):0]   vl_t;

  typedef struct packed {
    logic       vill;
    logic [2:0] vsew;
    logic [2:0] vlmul;
  } vtype_t;

  typedef enum logic [3:0] {
    OP_VSETVLI, OP_CSRW, OP_CSRS, OP_CSRC, OP_CSRR,
    OP_VADD_VV, OP_VADD_VX, OP_VMV_VX, OP_VREDSUM
  } op_e;

  typedef enum logic {UNIT_CON, UNIT_VFU} unit_e;

  typedef enum logic [1:0] {CSR_VSTART, CSR_VL, CSR_VTYPE, CSR_VLENB} csr_e;

  typedef struct packed {
    id_t    id;
    op_e    op;
    unit_e  unit;
    csr_e   csr;
    vreg_t  vd;
    vreg_t  vs1;
    vreg_t  vs2;
    elem_t  rs1;
    vtype_t vtype;
    logic   illegal;
  } decoded_t;

  typedef struct packed {
    id_t   id;
    op_e   op;
    vreg_t vd;
    vreg_t vs1;
    vreg_t vs2;
    elem_t rs1;
    vl_t   vl;
    vl_t   vstart;
  } vfu_req_t;

  typedef struct packed {
    id_t   id;
    elem_t data;
    logic  exc;
  } result_t;

endpackage

// File: vec_stream_if.sv
//////////////////////////////////////////////////////////////////////
// Valid/ready stream with a typed payload
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface vec_stream_if #(
  parameter type T = logic
);

  logic valid;
  logic ready;
  // Held stable while valid is high and ready is low
  T     payload;

  modport producer (
    output valid,
    output payload,
    input  ready
  );

  modport consumer (
    input  valid,
    input  payload,
    output ready
  );

endinterface

// File: vec_decoder.sv
//////////////////////////////////////////////////////////////////////
// Issue stage of the vector coprocessor
// Registers one instruction and classifies its RVV encoding
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module vec_decoder
  import vec_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  issue_valid_i,
  output logic                  issue_ready_o,
  input  logic [31:0]           issue_instr_i,
  input  elem_t                 issue_rs1_i,
  input  elem_t                 issue_rs2_i,
  input  id_t                   issue_id_i,
  vec_stream_if.producer        dec_o
);

  localparam logic [6:0]  OPC_OP_V       = 7'b1010111;
  localparam logic [6:0]  OPC_SYSTEM     = 7'b1110011;
  localparam logic [11:0] CSR_ADDR_START = 12'h008;
  localparam logic [11:0] CSR_ADDR_VL    = 12'hC20;
  localparam logic [11:0] CSR_ADDR_VTYPE = 12'hC21;
  localparam logic [11:0] CSR_ADDR_VLENB = 12'hC22;

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [5:0]  funct6;
  logic        vm;
  logic [4:0]  rd_f;
  logic [4:0]  rs1_f;
  logic [4:0]  rs2_f;
  logic [11:0] csr_addr;
  decoded_t    dec_d;
  decoded_t    dec_q;
  logic        valid_q;

  assign opcode   = issue_instr_i[6:0];
  assign rd_f     = issue_instr_i[11:7];
  assign funct3   = issue_instr_i[14:12];
  assign rs1_f    = issue_instr_i[19:15];
  assign rs2_f    = issue_instr_i[24:20];
  assign vm       = issue_instr_i[25];
  assign funct6   = issue_instr_i[31:26];
  assign csr_addr = issue_instr_i[31:20];

  always_comb begin : proc_decode
    dec_d         = '0;
    dec_d.id      = issue_id_i;
    dec_d.rs1     = issue_rs1_i;
    dec_d.vd      = rd_f[2:0];
    dec_d.vs1     = rs1_f[2:0];
    dec_d.vs2     = rs2_f[2:0];
    dec_d.illegal = 1'b1;
    // vsetvli immediate, reserved bits mark it ill
    dec_d.vtype   = '{vill: |issue_instr_i[30:28], vsew: issue_instr_i[25:23],
                      vlmul: issue_instr_i[22:20]};
    if (opcode == OPC_OP_V) begin
      dec_d.unit = UNIT_VFU;
      case (funct3)
        3'b111: begin
          dec_d.unit = UNIT_CON;
          dec_d.op   = OP_VSETVLI;
          if (!issue_instr_i[31]) begin
            dec_d.illegal = 1'b0;
          end
        end
        3'b000: begin
          dec_d.op      = OP_VADD_VV;
          dec_d.illegal = !(funct6 == 6'b000000 && vm &&
                            rd_f[4:3] == 2'b00 && rs1_f[4:3] == 2'b00 && rs2_f[4:3] == 2'b00);
        end
        3'b100: begin
          if (funct6 == 6'b000000) begin
            dec_d.op      = OP_VADD_VX;
            dec_d.illegal = !(vm && rd_f[4:3] == 2'b00 && rs2_f[4:3] == 2'b00);
          end else if (funct6 == 6'b010111) begin
            dec_d.op      = OP_VMV_VX;
            dec_d.illegal = !(vm && rd_f[4:3] == 2'b00 && rs2_f == 5'd0);
          end
        end
        3'b010: begin
          dec_d.op      = OP_VREDSUM;
          dec_d.illegal = !(funct6 == 6'b000000 && vm &&
                            rd_f[4:3] == 2'b00 && rs1_f[4:3] == 2'b00 && rs2_f[4:3] == 2'b00);
        end
        default: dec_d.illegal = 1'b1;
      endcase
    end else if (opcode == OPC_SYSTEM) begin
      if (csr_addr == CSR_ADDR_START && funct3[1:0] != 2'b00) begin
        dec_d.csr     = CSR_VSTART;
        dec_d.illegal = funct3[2];
        case (funct3[1:0])
          2'b01:   dec_d.op = OP_CSRW;
          2'b10:   dec_d.op = OP_CSRS;
          default: dec_d.op = OP_CSRC;
        endcase
      end else if (funct3 == 3'b010 && rs1_f == 5'd0) begin
        // Read-only vector CSRs
        dec_d.op      = OP_CSRR;
        dec_d.illegal = 1'b0;
        case (csr_addr)
          CSR_ADDR_VL:    dec_d.csr = CSR_VL;
          CSR_ADDR_VTYPE: dec_d.csr = CSR_VTYPE;
          CSR_ADDR_VLENB: dec_d.csr = CSR_VLENB;
          default:        dec_d.illegal = 1'b1;
        endcase
      end
    end
    // Illegal encodings are answered by the controller
    if (dec_d.illegal) begin
      dec_d.unit = UNIT_CON;
    end
  end

  // Accept when empty or draining this cycle
  assign issue_ready_o = !valid_q || dec_o.ready;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (issue_ready_o) begin
      valid_q <= issue_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_valid_i && issue_ready_o) begin
      dec_q <= dec_d;
    end
  end

  assign dec_o.valid   = valid_q;
  assign dec_o.payload = dec_q;

endmodule

// File: vec_controller.sv
//////////////////////////////////////////////////////////////////////
// Controller stage of the vector coprocessor
// Vector CSRs, vsetvli, dispatch to the unit, in-order results
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module vec_controller
  import vec_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_n_i,
  vec_stream_if.consumer  dec_i,
  vec_stream_if.producer  vfu_o,
  vec_stream_if.consumer  vres_i,
  output logic            result_valid_o,
  input  logic            result_ready_i,
  output id_t             result_id_o,
  output elem_t           result_data_o,
  output logic            result_exc_o
);

  decoded_t dec;
  vl_t      vstart_q, vstart_d;
  vl_t      vl_q, vl_d;
  vtype_t   vtype_q, vtype_d;
  logic     busy_q;
  logic     res_valid_q;
  result_t  res_q, res_d;
  logic     res_free;
  logic     to_unit;
  logic     con_fire;
  logic     vfu_fire;
  logic     vres_fire;
  logic     vtype_ok;
  vl_t      vlmax;

  assign dec      = dec_i.payload;
  assign res_free = !res_valid_q || result_ready_i;
  // Arithmetic only reaches the unit with a legal vtype
  assign to_unit  = dec.unit == UNIT_VFU && !vtype_q.vill;

  ////////////////////////////////////////////////////////////////////
  // Handshakes
  ////////////////////////////////////////////////////////////////////

  // Unit results win the result register
  assign vres_i.ready  = res_free;
  assign vres_fire     = vres_i.valid && res_free;
  assign vfu_o.valid   = dec_i.valid && to_unit;
  assign vfu_o.payload = '{id: dec.id, op: dec.op, vd: dec.vd, vs1: dec.vs1, vs2: dec.vs2,
                           rs1: dec.rs1, vl: vl_q, vstart: vstart_q};
  // Local instructions wait for the unit to drain so results stay ordered
  assign dec_i.ready   = to_unit ? vfu_o.ready : (!busy_q && res_free);
  assign vfu_fire      = vfu_o.valid && vfu_o.ready;
  assign con_fire      = dec_i.valid && dec_i.ready && !to_unit;

  ////////////////////////////////////////////////////////////////////
  // CSR execution
  ////////////////////////////////////////////////////////////////////

  always_comb begin : proc_csr
    vstart_d = vstart_q;
    vl_d     = vl_q;
    vtype_d  = vtype_q;
    res_d    = res_q;
    vtype_ok = !dec.vtype.vill && dec.vtype.vsew == SEW_32 &&
               (dec.vtype.vlmul == LMUL_1 || dec.vtype.vlmul == LMUL_F2 ||
                dec.vtype.vlmul == LMUL_F4);
    case (dec.vtype.vlmul)
      LMUL_F2: vlmax = vl_t'(VLMAX >> 1);
      LMUL_F4: vlmax = vl_t'(VLMAX >> 2);
      default: vlmax = vl_t'(VLMAX);
    endcase
    if (vres_fire) begin
      res_d = vres_i.payload;
    end else if (con_fire) begin
      res_d = '{id: dec.id, data: '0, exc: 1'b0};
      if (dec.illegal || dec.unit == UNIT_VFU) begin
        res_d.exc = 1'b1;
      end else begin
        case (dec.op)
          OP_VSETVLI: begin
            vstart_d = '0;
            if (vtype_ok) begin
              vtype_d = dec.vtype;
              // An all-ones AVL also lands on vlmax here
              vl_d    = (dec.rs1 < elem_t'(vlmax)) ? vl_t'(dec.rs1) : vlmax;
            end else begin
              vtype_d = '{vill: 1'b1, default: '0};
              vl_d    = '0;
            end
            res_d.data = elem_t'(vl_d);
          end
          OP_CSRW: begin
            res_d.data = elem_t'(vstart_q);
            vstart_d   = vl_t'(dec.rs1);
          end
          OP_CSRS: begin
            res_d.data = elem_t'(vstart_q);
            vstart_d   = vstart_q | vl_t'(dec.rs1);
          end
          OP_CSRC: begin
            res_d.data = elem_t'(vstart_q);
            vstart_d   = vstart_q & ~vl_t'(dec.rs1);
          end
          OP_CSRR: begin
            case (dec.csr)
              CSR_VSTART: res_d.data = elem_t'(vstart_q);
              CSR_VL:     res_d.data = elem_t'(vl_q);
              CSR_VTYPE:  res_d.data = {vtype_q.vill, 25'b0, vtype_q.vsew, vtype_q.vlmul};
              default:    res_d.data = elem_t'(VLENB);
            endcase
          end
          default: res_d.exc = 1'b1;
        endcase
      end
    end
    // Dispatched arithmetic consumes vstart
    if (vfu_fire) begin
      vstart_d = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      vstart_q    <= '0;
      vl_q        <= '0;
      vtype_q     <= '{vill: 1'b1, default: '0};
      busy_q      <= 1'b0;
      res_valid_q <= 1'b0;
    end else begin
      vstart_q <= vstart_d;
      vl_q     <= vl_d;
      vtype_q  <= vtype_d;
      if (vfu_fire) begin
        busy_q <= 1'b1;
      end else if (vres_fire) begin
        busy_q <= 1'b0;
      end
      if (vres_fire || con_fire) begin
        res_valid_q <= 1'b1;
      end else if (result_ready_i) begin
        res_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    res_q <= res_d;
  end

  assign result_valid_o = res_valid_q;
  assign result_id_o    = res_q.id;
  assign result_data_o  = res_q.data;
  assign result_exc_o   = res_q.exc;

endmodule

// File: vec_vfu.sv
//////////////////////////////////////////////////////////////////////
// Vector functional unit with its register file
// Element-wise add and move, sum reduction
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module vec_vfu
  import vec_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_n_i,
  vec_stream_if.consumer  req_i,
  vec_stream_if.producer  res_o
);

  typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_DONE} state_e;

  state_e                state_q;
  vfu_req_t              req_q;
  vl_t                   idx_q;
  elem_t                 acc_q;
  elem_t                 rf_q [NREGS][NELEM];
  elem_t                 elem_res;
  logic                  active;
  logic [ELEM_IDX_W-1:0] eidx;

  assign req_i.ready   = state_q == ST_IDLE;
  assign res_o.valid   = state_q == ST_DONE;
  assign res_o.payload = '{id: req_q.id, data: (req_q.op == OP_VREDSUM) ? acc_q : '0,
                           exc: 1'b0};

  // One element per cycle from vstart up to vl - 1
  assign active = state_q == ST_RUN && idx_q < req_q.vl;
  assign eidx   = idx_q[ELEM_IDX_W-1:0];

  always_comb begin : proc_elem
    case (req_q.op)
      OP_VADD_VV: elem_res = rf_q[req_q.vs2][eidx] + rf_q[req_q.vs1][eidx];
      OP_VADD_VX: elem_res = rf_q[req_q.vs2][eidx] + req_q.rs1;
      OP_VMV_VX:  elem_res = req_q.rs1;
      default:    elem_res = rf_q[req_q.vd][eidx];
    endcase
  end

  ////////////////////////////////////////////////////////////////////
  // Sequencing and register file
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      for (int r = 0; r < NREGS; r++) begin
        for (int e = 0; e < NELEM; e++) begin
          rf_q[r][e] <= '0;
        end
      end
    end else begin
      case (state_q)
        ST_IDLE: if (req_i.valid) state_q <= ST_RUN;
        ST_RUN: begin
          if (!active) begin
            state_q <= ST_DONE;
          end else if (req_q.op != OP_VREDSUM) begin
            rf_q[req_q.vd][eidx] <= elem_res;
          end
        end
        default: if (res_o.ready) state_q <= ST_IDLE;
      endcase
    end
  end

  // Command, element index and reduction sum
  always_ff @(posedge clk_i) begin
    if (req_i.valid && req_i.ready) begin
      req_q <= req_i.payload;
      idx_q <= req_i.payload.vstart;
      acc_q <= rf_q[req_i.payload.vs1][0];
    end else if (active) begin
      idx_q <= idx_q + 1'b1;
      acc_q <= acc_q + rf_q[req_q.vs2][eidx];
    end
  end

endmodule

// File: vec_top.sv
//////////////////////////////////////////////////////////////////////
// Vector coprocessor front end top level
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module vec_top
  import vec_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  // Issue channel
  input  logic        issue_valid_i,
  output logic        issue_ready_o,
  input  logic [31:0] issue_instr_i,
  input  elem_t       issue_rs1_i,
  input  elem_t       issue_rs2_i,
  input  id_t         issue_id_i,
  // Result channel
  output logic        result_valid_o,
  input  logic        result_ready_i,
  output id_t         result_id_o,
  output elem_t       result_data_o,
  output logic        result_exc_o
);

  vec_stream_if #(.T(decoded_t)) dec_if ();
  vec_stream_if #(.T(vfu_req_t)) vfu_if ();
  vec_stream_if #(.T(result_t))  res_if ();

  vec_decoder i_decoder (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .issue_valid_i(issue_valid_i),
    .issue_ready_o(issue_ready_o),
    .issue_instr_i(issue_instr_i),
    .issue_rs1_i  (issue_rs1_i),
    .issue_rs2_i  (issue_rs2_i),
    .issue_id_i   (issue_id_i),
    .dec_o        (dec_if.producer)
  );

  vec_controller i_controller (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .dec_i         (dec_if.consumer),
    .vfu_o         (vfu_if.producer),
    .vres_i        (res_if.consumer),
    .result_valid_o(result_valid_o),
    .result_ready_i(result_ready_i),
    .result_id_o   (result_id_o),
    .result_data_o (result_data_o),
    .result_exc_o  (result_exc_o)
  );

  vec_vfu i_vfu (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .req_i  (vfu_if.consumer),
    .res_o  (res_if.producer)
  );

endmodule

// File: vec_tb.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the vector coprocessor front end
// Clock, reset, issue and result tasks, CSR and register model
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "vec_params.svh"

module vec_tb;

  localparam int TIMEOUT   = 200;
  localparam int VLENB_EXP = `VEC_VLEN / 8;
  localparam int NELEM_EXP = `VEC_VLEN / 32;
  localparam int K_VV      = 0;
  localparam int K_VX      = 1;
  localparam int K_MV      = 2;
  localparam int K_RED     = 3;

  logic                 clk_i;
  logic                 rst_n_i;
  logic                 issue_valid_i;
  logic                 issue_ready_o;
  logic [31:0]          issue_instr_i;
  logic [31:0]          issue_rs1_i;
  logic [31:0]          issue_rs2_i;
  logic [`VEC_ID_W-1:0] issue_id_i;
  logic                 result_valid_o;
  logic                 result_ready_i;
  logic [`VEC_ID_W-1:0] result_id_o;
  logic [31:0]          result_data_o;
  logic                 result_exc_o;

  // Reference model of the CSRs and the register file
  logic [31:0]          m_rf [`VEC_NREGS][NELEM_EXP];
  int                   m_vl;
  int                   m_vstart;
  logic                 m_vill;
  logic [2:0]           m_vsew;
  logic [2:0]           m_vlmul;

  // Expected results in issue order
  logic [`VEC_ID_W-1:0] exp_id_q [$];
  logic [31:0]          exp_data_q [$];
  logic                 exp_exc_q [$];
  logic [`VEC_ID_W-1:0] next_id;
  integer               seed;

  vec_top DUT (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .issue_valid_i (issue_valid_i),
    .issue_ready_o (issue_ready_o),
    .issue_instr_i (issue_instr_i),
    .issue_rs1_i   (issue_rs1_i),
    .issue_rs2_i   (issue_rs2_i),
    .issue_id_i    (issue_id_i),
    .result_valid_o(result_valid_o),
    .result_ready_i(result_ready_i),
    .result_id_o   (result_id_o),
    .result_data_o (result_data_o),
    .result_exc_o  (result_exc_o)
  );

  always #4 clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // Instruction encodings
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] enc_opv(input logic [5:0] f6, input logic [4:0] vs2,
                                          input logic [4:0] vs1, input logic [2:0] f3,
                                          input logic [4:0] vd);
    return {f6, 1'b1, vs2, vs1, f3, vd, 7'b1010111};
  endfunction

  // vsetvli x5, x6 with vta and vma clear
  function automatic logic [31:0] enc_vsetvli(input logic [2:0] sew, input logic [2:0] lmul);
    return {1'b0, 5'b00000, sew, lmul, 5'd6, 3'b111, 5'd5, 7'b1010111};
  endfunction

  function automatic logic [31:0] enc_csr(input logic [11:0] addr, input logic [4:0] rs1f,
                                          input logic [2:0] f3);
    return {addr, rs1f, f3, 5'd5, 7'b1110011};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Driver and checker
  //////////////////////////////////////////////////////////////////////

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      $display("FAIL: see errors above");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic issue_instr(input logic [31:0] instr, input logic [31:0] rs1);
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    issue_valid_i = 1'b1;
    issue_instr_i = instr;
    issue_rs1_i   = rs1;
    issue_id_i    = next_id;
    #1;
    while (!issue_ready_o) begin
      if (cycles >= TIMEOUT) begin
        $display("Timeout: the DUT never accepted instruction %h", instr);
        $display("FAIL: see errors above");
        $fatal(1, "Issue timeout");
      end else begin
        @(negedge clk_i);
        #1;
        cycles++;
      end
    end
    @(posedge clk_i);
    @(negedge clk_i);
    issue_valid_i = 1'b0;
    next_id       = next_id + 1'b1;
  endtask

  task automatic expect_result();
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    result_ready_i = 1'b1;
    #1;
    while (!result_valid_o) begin
      if (cycles >= TIMEOUT) begin
        $display("Timeout: no result arrived from the DUT");
        $display("FAIL: see errors above");
        $fatal(1, "Result timeout");
      end else begin
        @(negedge clk_i);
        #1;
        cycles++;
      end
    end
    if (exp_id_q.size() == 0) begin
      $display("The DUT returned a result with no instruction outstanding");
      $display("FAIL: see errors above");
      $fatal(1, "Unexpected result");
    end else begin
      check_eq("result_id_o", 32'(exp_id_q.pop_front()), 32'(result_id_o));
      check_eq("result_data_o", exp_data_q.pop_front(), result_data_o);
      check_eq("result_exc_o", 32'(exp_exc_q.pop_front()), 32'(result_exc_o));
      @(posedge clk_i);
      @(negedge clk_i);
      result_ready_i = 1'b0;
    end
  endtask

  // Optionally holds result_ready_i low for a random stretch before each result
  task automatic expect_n(input int n, input logic stall);
    int idle;
    for (int k = 0; k < n; k++) begin
      if (stall) begin
        idle = $unsigned($random(seed)) % 6;
        repeat (idle) @(negedge clk_i);
      end
      expect_result();
    end
  endtask

  task automatic push_exp(input logic [31:0] data, input logic exc);
    exp_id_q.push_back(next_id);
    exp_data_q.push_back(data);
    exp_exc_q.push_back(exc);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Instruction senders with model update
  //////////////////////////////////////////////////////////////////////

  task automatic send_vsetvli(input logic [2:0] sew, input logic [2:0] lmul,
                              input logic [31:0] avl);
    int vlmax;
    vlmax = (lmul == 3'b111) ? NELEM_EXP / 2 : (lmul == 3'b110) ? NELEM_EXP / 4 : NELEM_EXP;
    m_vstart = 0;
    if (sew == 3'b010 && (lmul == 3'b000 || lmul == 3'b111 || lmul == 3'b110)) begin
      m_vill  = 1'b0;
      m_vsew  = sew;
      m_vlmul = lmul;
      m_vl    = (avl < vlmax) ? int'(avl) : vlmax;
    end else begin
      m_vill  = 1'b1;
      m_vsew  = 3'b000;
      m_vlmul = 3'b000;
      m_vl    = 0;
    end
    push_exp(m_vl, 1'b0);
    issue_instr(enc_vsetvli(sew, lmul), avl);
  endtask

  // csrrw, csrrs or csrrc on vstart, returning the old value
  task automatic send_csr(input logic [2:0] f3, input logic [31:0] val);
    push_exp(m_vstart, 1'b0);
    case (f3)
      3'b001:  m_vstart = val;
      3'b010:  m_vstart = m_vstart | val;
      default: m_vstart = m_vstart & ~val;
    endcase
    issue_instr(enc_csr(12'h008, 5'd6, f3), val);
  endtask

  task automatic send_csrr(input logic [11:0] addr);
    logic [31:0] val;
    case (addr)
      12'hC20: val = m_vl;
      12'hC21: val = {m_vill, 25'b0, m_vsew, m_vlmul};
      default: val = VLENB_EXP;
    endcase
    push_exp(val, 1'b0);
    issue_instr(enc_csr(addr, 5'd0, 3'b010), 32'h0);
  endtask

  task automatic send_vop(input int kind, input logic [2:0] vd, input logic [2:0] vs1,
                          input logic [2:0] vs2, input logic [31:0] rs1);
    logic [31:0] instr;
    logic [31:0] sum;
    int          i;
    case (kind)
      K_VV:    instr = enc_opv(6'b000000, {2'b00, vs2}, {2'b00, vs1}, 3'b000, {2'b00, vd});
      K_VX:    instr = enc_opv(6'b000000, {2'b00, vs2}, 5'd10, 3'b100, {2'b00, vd});
      K_MV:    instr = enc_opv(6'b010111, 5'd0, 5'd10, 3'b100, {2'b00, vd});
      default: instr = enc_opv(6'b000000, {2'b00, vs2}, {2'b00, vs1}, 3'b010, {2'b00, vd});
    endcase
    if (m_vill) begin
      push_exp(32'h0, 1'b1);
    end else begin
      sum = m_rf[vs1][0];
      // Active elements run from vstart to vl - 1
      for (i = m_vstart; i < m_vl; i++) begin
        case (kind)
          K_VV:    m_rf[vd][i] = m_rf[vs2][i] + m_rf[vs1][i];
          K_VX:    m_rf[vd][i] = m_rf[vs2][i] + rs1;
          K_MV:    m_rf[vd][i] = rs1;
          default: sum = sum + m_rf[vs2][i];
        endcase
      end
      m_vstart = 0;
      push_exp((kind == K_RED) ? sum : 32'h0, 1'b0);
    end
    issue_instr(instr, rs1);
  endtask

  task automatic send_raw(input logic [31:0] instr);
    push_exp(32'h0, 1'b1);
    issue_instr(instr, 32'h0);
  endtask

  task automatic send_random_op();
    logic [31:0] r;
    logic [31:0] d;
    logic [2:0]  lmul;
    r = $random(seed);
    d = $random(seed);
    // LMUL 2 is unsupported and sets vill
    lmul = (r[15:14] == 2'd1) ? 3'b111 : (r[15:14] == 2'd2) ? 3'b110 :
           (r[15:14] == 2'd3) ? 3'b001 : 3'b000;
    case (r[13:11])
      3'd0:    send_vsetvli(3'b010, lmul, {29'b0, r[18:16]});
      3'd1:    send_csr(3'b001, {30'b0, r[21:20]});
      3'd2:    send_csrr(12'hC20);
      3'd3:    send_csrr(12'hC21);
      3'd4:    send_raw(enc_opv(6'b000010, 5'd1, 5'd2, 3'b000, 5'd3));
      default: send_vop(int'(r[10:9]), r[2:0], r[5:3], r[8:6], d);
    endcase
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    send_csrr(12'hC21);
    expect_result();
    send_csrr(12'hC20);
    expect_result();
    send_csrr(12'hC22);
    expect_result();
    send_vop(K_VV, 3'd1, 3'd2, 3'd3, 32'h0);
    expect_result();
  endtask

  task automatic test_vsetvli();
    logic [31:0] avls [4];
    logic [2:0]  lmuls [3];
    avls  = '{32'd0, 32'd3, 32'd9, 32'hFFFF_FFFF};
    lmuls = '{3'b000, 3'b111, 3'b110};
    for (int a = 0; a < 4; a++) begin
      for (int l = 0; l < 3; l++) begin
        send_vsetvli(3'b010, lmuls[l], avls[a]);
        expect_result();
      end
    end
    // SEW 8
    send_vsetvli(3'b000, 3'b000, 32'd4);
    expect_result();
    send_csrr(12'hC20);
    expect_result();
    send_csrr(12'hC21);
    expect_result();
  endtask

  task automatic test_arith();
    for (int a = 4; a >= 2; a--) begin
      send_vsetvli(3'b010, (a == 2) ? 3'b111 : 3'b000, a);
      expect_result();
      // v7 holds the known reduction seed
      send_vop(K_MV, 3'd7, 3'd0, 3'd0, 32'd100);
      expect_result();
      send_vop(K_MV, 3'd1, 3'd0, 3'd0, $random(seed));
      expect_result();
      send_vop(K_RED, 3'd3, 3'd7, 3'd1, 32'h0);
      expect_result();
      send_vop(K_VX, 3'd4, 3'd0, 3'd1, $random(seed));
      expect_result();
      send_vop(K_RED, 3'd3, 3'd7, 3'd4, 32'h0);
      expect_result();
      send_vop(K_VV, 3'd5, 3'd1, 3'd4, 32'h0);
      expect_result();
      send_vop(K_RED, 3'd3, 3'd7, 3'd5, 32'h0);
      expect_result();
    end
  endtask

  task automatic test_vstart();
    send_vsetvli(3'b010, 3'b000, 32'd4);
    expect_result();
    send_vop(K_MV, 3'd6, 3'd0, 3'd0, 32'd5);
    expect_result();
    send_csr(3'b001, 32'd2);
    expect_result();
    send_vop(K_VX, 3'd6, 3'd0, 3'd6, 32'd10);
    expect_result();
    send_csr(3'b010, 32'd0);
    expect_result();
    send_vop(K_RED, 3'd3, 3'd7, 3'd6, 32'h0);
    expect_result();
    // Elements 0 and 1 alone must still hold 5
    send_vsetvli(3'b010, 3'b000, 32'd2);
    expect_result();
    send_vop(K_RED, 3'd3, 3'd7, 3'd6, 32'h0);
    expect_result();
    send_csr(3'b010, 32'd3);
    expect_result();
    send_csr(3'b011, 32'd1);
    expect_result();
    send_csr(3'b001, 32'd0);
    expect_result();
  endtask

  task automatic test_order();
    fork
      begin
        send_raw(enc_opv(6'b000010, 5'd2, 5'd1, 3'b000, 5'd3));
        send_csrr(12'hC20);
        send_raw(32'h0000_0013);
        send_vop(K_RED, 3'd3, 3'd7, 3'd1, 32'h0);
        send_vop(K_VX, 3'd2, 3'd0, 3'd1, 32'd7);
        send_csrr(12'hC22);
      end
      expect_n(6, 1'b0);
    join
  endtask

  task automatic test_backpressure();
    fork
      begin
        for (int n = 0; n < 24; n++) begin
          send_random_op();
        end
      end
      expect_n(24, 1'b1);
    join
  endtask

  initial begin
    clk_i          = 1'b0;
    rst_n_i        = 1'b0;
    issue_valid_i  = 1'b0;
    issue_instr_i  = 32'h0;
    issue_rs1_i    = 32'h0;
    issue_rs2_i    = 32'h0;
    issue_id_i     = '0;
    result_ready_i = 1'b0;
    next_id        = '0;
    seed           = 51;
    m_vl           = 0;
    m_vstart       = 0;
    m_vill         = 1'b1;
    m_vsew         = 3'b000;
    m_vlmul        = 3'b000;
    for (int r = 0; r < `VEC_NREGS; r++) begin
      for (int e = 0; e < NELEM_EXP; e++) begin
        m_rf[r][e] = 32'h0;
      end
    end
    repeat (2) @(negedge clk_i);
    rst_n_i = 1'b1;

    test_reset_state();
    test_vsetvli();
    test_arith();
    test_vstart();
    test_order();
    test_backpressure();

    $display("PASS: all tests");
    $finish;
  end

endmodule

// File: compile.f
+incdir+.
vec_pkg.sv
vec_stream_if.sv
vec_decoder.sv
vec_controller.sv
vec_vfu.sv
vec_top.sv
vec_tb.sv

// File: run.sh
#!/bin/sh
# Build the vector coprocessor testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --top-module vec_tb -f compile.f -Mdir obj_dir -o vec_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/vec_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

exit 0
